//--- Bender.yml
package:
  name: multi_cycle_scalar_alu

sources:
  # Design sources in compile order
  - src/mc_alu_pkg.sv
  - src/mc_stage_if.sv
  - src/mc_operand_unpack.sv
  - src/mc_product_pipe.sv
  - src/mc_normalize_pack.sv
  - src/multi_cycle_scalar_alu.sv

  # Testbench and assertions
  - target: simulation
    files:
      - sim/mc_alu_sva.sv
      - sim/tb_multi_cycle_scalar_alu.sv

//--- sim/mc_alu_sva.sv
/*
 * Assertions for the multi-cycle scalar unit
 * Reset quiet period, fixed strobe latency and known results
 */

`timescale 1ns/1ps
`default_nettype none

module mc_alu_sva
	import mc_alu_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input wire                   clk,
	input wire                   reset,
	input wire                   valid_i,
	input wire                   valid_o,
	input wire [WORD_WIDTH-1:0]  result_o
);

	localparam int LATENCY = MUL_STAGES + 1;

	// Counts edges since reset up to the pipeline latency
	int since_reset;

	// Number of failed checks
	int assert_failures = 0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			since_reset <= 0;
		else if (since_reset < LATENCY)
			since_reset <= since_reset + 1;
	end

	// Pipeline still empty right after reset
	assert property (@(posedge clk) disable iff (reset) since_reset < LATENCY |-> !valid_o)
		else
		begin
			assert_failures++;
			$error("valid_o high while the pipeline is still empty after reset");
		end

	assert property (@(posedge clk) disable iff (reset)
		since_reset >= LATENCY |-> valid_o == $past(valid_i, LATENCY))
		else
		begin
			assert_failures++;
			$error("valid_o does not follow valid_i by the pipeline latency");
		end

	assert property (@(posedge clk) disable iff (reset) valid_o |-> !$isunknown(result_o))
		else
		begin
			assert_failures++;
			$error("result_o has unknown bits while valid_o is high");
		end

endmodule

`default_nettype wire

//--- sim/tb_multi_cycle_scalar_alu.sv
/*
 * Testbench for the multi-cycle scalar unit
 * Directed table, back-to-back random issue and an in-order result check
 */

`timescale 1ns/1ps
`default_nettype none

module tb_multi_cycle_scalar_alu
	import mc_alu_pkg::*;
();

	localparam int MUL_STAGES = 3;
	localparam int LATENCY = MUL_STAGES + 1;
	localparam int DIRECTED_COUNT = 21;
	localparam int RANDOM_COUNT = 200;
	localparam int CYCLE_LIMIT = DIRECTED_COUNT + RANDOM_COUNT + MUL_STAGES + 50;

	typedef struct packed {
		alu_op_e               op;
		logic [WORD_WIDTH-1:0] operand1;
		logic [WORD_WIDTH-1:0] operand2;
		logic [WORD_WIDTH-1:0] expected;
	} vector_t;

	typedef struct packed {
		vector_t vec;
		int      issue_cycle;
	} pending_t;

	logic                  clk;
	logic                  reset;
	logic                  valid_i;
	alu_op_e               op_i;
	logic [WORD_WIDTH-1:0] operand1_i;
	logic [WORD_WIDTH-1:0] operand2_i;
	logic                  valid_o;
	logic [WORD_WIDTH-1:0] result_o;

	int          cycle_count;
	int          check_count;
	int          error_count;
	logic [31:0] rng_state;
	pending_t    pending_q [$];

	// op, operand1, operand2, expected
	vector_t directed_table [DIRECTED_COUNT] = '{
		'{OP_IMUL, 32'h0000_0007, 32'h0000_0006, 32'h0000_002A},
		'{OP_IMUL, 32'hFFFF_FFFD, 32'h0000_0005, 32'hFFFF_FFF1},
		'{OP_IMUL, 32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFE},
		'{OP_IMUL, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000},
		'{OP_IMUL, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000},
		'{OP_FMUL, 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000},
		'{OP_FMUL, 32'hC040_0000, 32'h3E80_0000, 32'hBF40_0000},
		'{OP_FMUL, 32'h3FFF_FFFF, 32'h3FFF_FFFF, 32'h407F_FFFE},
		'{OP_FMUL, 32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000},
		'{OP_FMUL, 32'h7F80_0001, 32'h0000_0000, 32'h7FC0_0000},
		'{OP_FMUL, 32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000},
		'{OP_FMUL, 32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000},
		'{OP_FMUL, 32'hFF80_0000, 32'hBF80_0000, 32'h7F80_0000},
		'{OP_FMUL, 32'hFF00_0000, 32'h4000_0000, 32'hFF80_0000},
		'{OP_FMUL, 32'h8080_0000, 32'h3F00_0000, 32'h8000_0000},
		'{OP_FMUL, 32'h8000_0000, 32'h40A0_0000, 32'h8000_0000},
		'{OP_ITOF, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
		'{OP_ITOF, 32'h0000_0001, 32'h0000_0000, 32'h3F80_0000},
		'{OP_ITOF, 32'hFFFF_FFFF, 32'h0000_0000, 32'hBF80_0000},
		'{OP_ITOF, 32'h7FFF_FFFF, 32'h0000_0000, 32'h4EFF_FFFF},
		'{OP_ITOF, 32'h8000_0000, 32'h0000_0000, 32'hCF00_0000}
	};

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	multi_cycle_scalar_alu #(
		.MUL_STAGES (MUL_STAGES)
	) u_multi_cycle_scalar_alu (
		.clk        (clk),
		.reset      (reset),
		.valid_i    (valid_i),
		.op_i       (op_i),
		.operand1_i (operand1_i),
		.operand2_i (operand2_i),
		.valid_o    (valid_o),
		.result_o   (result_o)
	);

	bind multi_cycle_scalar_alu mc_alu_sva #(
		.MUL_STAGES (MUL_STAGES)
	) u_mc_alu_sva (
		.clk      (clk),
		.reset    (reset),
		.valid_i  (valid_i),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// Expected result straight from the unit's arithmetic rules
	function automatic logic [WORD_WIDTH-1:0] model_result(alu_op_e op,
		logic [WORD_WIDTH-1:0] a, logic [WORD_WIDTH-1:0] b);
		logic [7:0]  ea;
		logic [7:0]  eb;
		logic [23:0] sa;
		logic [23:0] sb;
		logic [31:0] mag;
		logic [63:0] prod;
		logic [63:0] shifted;
		logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
		logic        sign, nan_flag, inf_flag;
		int          scale, pos, expo;
		ea = a[30:23];
		eb = b[30:23];
		a_zero = ea == 8'h00;
		b_zero = eb == 8'h00;
		a_inf = ea == 8'hFF && a[22:0] == 23'h0;
		b_inf = eb == 8'hFF && b[22:0] == 23'h0;
		a_nan = ea == 8'hFF && a[22:0] != 23'h0;
		b_nan = eb == 8'hFF && b[22:0] != 23'h0;
		nan_flag = 1'b0;
		inf_flag = 1'b0;
		case (op)
			OP_IMUL:
				return a * b;
			OP_FMUL:
			begin
				sa = a_zero ? 24'h0 : {1'b1, a[22:0]};
				sb = b_zero ? 24'h0 : {1'b1, b[22:0]};
				prod = 64'(sa) * 64'(sb);
				scale = int'(ea) + int'(eb) - 127 - 46;
				sign = a[31] ^ b[31];
				nan_flag = a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf);
				inf_flag = !nan_flag && (a_inf || b_inf);
			end
			OP_ITOF:
			begin
				mag = a[31] ? -a : a;
				prod = 64'(mag);
				scale = 127;
				sign = a[31];
			end
			default:
				return '0;
		endcase
		if (nan_flag)
			return 32'h7FC0_0000;
		if (inf_flag)
			return {sign, 8'hFF, 23'h0};
		if (prod == 64'h0)
			return {sign, 31'h0};
		pos = 0;
		for (int i = 0; i < 64; i++)
		begin
			if (prod[i])
				pos = i;
		end
		expo = scale + pos;
		if (expo >= 255)
			return {sign, 8'hFF, 23'h0};
		if (expo <= 0)
			return {sign, 31'h0};
		shifted = prod << (63 - pos);
		return {sign, 8'(expo), shifted[62:40]};
	endfunction

	function automatic string float_category(logic [WORD_WIDTH-1:0] w);
		if (w[30:23] == 8'hFF)
			return (w[22:0] != 23'h0) ? "NaN" : "inf";
		if (w[30:23] == 8'h00)
			return "zero";
		return "normal";
	endfunction

	task automatic check_word(logic [WORD_WIDTH-1:0] got, logic [WORD_WIDTH-1:0] expected);
		check_count++;
		if (got !== expected)
		begin
			$display("Error %0t: IMUL result %h, expected %h", $time, got, expected);
			error_count++;
		end
	endtask

	task automatic check_float(alu_op_e op, logic [WORD_WIDTH-1:0] got,
		logic [WORD_WIDTH-1:0] expected);
		check_count++;
		if (got !== expected)
		begin
			$display("Error %0t: %s result %h (%s), expected %h (%s)", $time, op.name(),
				got, float_category(got), expected, float_category(expected));
			error_count++;
		end
	endtask

	task automatic issue_op(vector_t v);
		pending_t entry;
		@(negedge clk);
		valid_i = 1'b1;
		op_i = v.op;
		operand1_i = v.operand1;
		operand2_i = v.operand2;
		entry.vec = v;
		entry.issue_cycle = cycle_count;
		pending_q.push_back(entry);
	endtask

	// Waits for outstanding results, then watches a few quiet cycles for stray strobes
	task automatic finish_test(string name, int checks_before, int errors_before);
		int waited;
		@(negedge clk);
		valid_i = 1'b0;
		waited = 0;
		while (pending_q.size() != 0 && waited < LATENCY + 2)
		begin
			@(negedge clk);
			waited++;
		end
		if (pending_q.size() != 0)
		begin
			$display("Missing valid_o for %0d operations in test %s", pending_q.size(), name);
			error_count += pending_q.size();
			pending_q.delete();
		end
		repeat (MUL_STAGES + 2) @(negedge clk);
		$display("Test %s finished: %0d results checked, %0d errors", name,
			check_count - checks_before, error_count - errors_before);
	endtask

	// Each valid_o is matched against the oldest operation in flight
	always @(negedge clk)
	begin
		pending_t entry;
		if (!reset && valid_o === 1'b1)
		begin
			if (pending_q.size() == 0)
			begin
				$display("Unexpected valid_o at %0t with no operation in flight", $time);
				error_count++;
			end
			else
			begin
				entry = pending_q.pop_front();
				if (cycle_count - entry.issue_cycle != LATENCY)
				begin
					$display("Error %0t: result came %0d cycles after issue, expected %0d",
						$time, cycle_count - entry.issue_cycle, LATENCY);
					error_count++;
				end
				if (entry.vec.op == OP_IMUL)
					check_word(result_o, entry.vec.expected);
				else
					check_float(entry.vec.op, result_o, entry.vec.expected);
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		vector_t     rand_vec;
		logic [31:0] sel;
		int          checks_before;
		int          errors_before;
		reset = 1'b1;
		valid_i = 1'b0;
		op_i = OP_IMUL;
		operand1_i = '0;
		operand2_i = '0;
		rng_state = 32'd15199;
		check_count = 0;
		error_count = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Nothing issued yet, so valid_o must stay low
		errors_before = error_count;
		repeat (4) @(negedge clk);
		$display("Test reset_idle finished: %0d errors", error_count - errors_before);

		checks_before = check_count;
		errors_before = error_count;
		for (int i = 0; i < DIRECTED_COUNT; i++)
			issue_op(directed_table[i]);
		finish_test("directed", checks_before, errors_before);

		// Mixed opcodes on every cycle with no gaps
		checks_before = check_count;
		errors_before = error_count;
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			sel = xorshift32();
			rand_vec.operand1 = xorshift32();
			rand_vec.operand2 = xorshift32();
			case (sel % 3)
				0: rand_vec.op = OP_IMUL;
				1: rand_vec.op = OP_FMUL;
				default: rand_vec.op = OP_ITOF;
			endcase
			// Mostly mid-range exponents so normal products dominate
			if (rand_vec.op == OP_FMUL && sel[21:20] != 2'b00)
			begin
				rand_vec.operand1[30:23] = 8'd96 + 8'(sel[13:8]);
				rand_vec.operand2[30:23] = 8'd96 + 8'(sel[19:14]);
			end
			rand_vec.expected = model_result(rand_vec.op, rand_vec.operand1,
				rand_vec.operand2);
			issue_op(rand_vec);
		end
		finish_test("random_back_to_back", checks_before, errors_before);

		$display("Checked %0d results, %0d errors, %0d assertion failures", check_count,
			error_count, u_multi_cycle_scalar_alu.u_mc_alu_sva.assert_failures);
		if (error_count == 0 && check_count == DIRECTED_COUNT + RANDOM_COUNT
			&& u_multi_cycle_scalar_alu.u_mc_alu_sva.assert_failures == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/mc_alu_pkg.sv
/*
 * Multi-cycle scalar unit shared definitions
 * Opcodes, word and float field widths, and the special result constants
 */

`default_nettype none

package mc_alu_pkg;

	// Operations handled by the multi-cycle unit, the fourth code yields zero
	typedef enum logic [1:0] {
		OP_IMUL = 2'd0,
		OP_FMUL = 2'd1,
		OP_ITOF = 2'd2
	} alu_op_e;

	// Operand and result word
	localparam int WORD_WIDTH = 32;

	// Single precision fields
	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;
	localparam int SIG_WIDTH = FRAC_WIDTH + 1;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 255;

	// Product of two 24-bit significands has its binary point 46 places up
	localparam int FMUL_SCALE_ADJ = EXP_BIAS + 2 * FRAC_WIDTH;

	// Full 32x32 product from the shared multiplier
	localparam int PRODUCT_WIDTH = 64;

	// Signed scale exponent, room for underflow and overflow
	localparam int SCALE_WIDTH = 10;

	// Every NaN result collapses to this quiet NaN
	localparam logic [WORD_WIDTH-1:0] QNAN_WORD = 32'h7FC0_0000;

endpackage

`default_nettype wire

//--- src/mc_normalize_pack.sv
/*
 * Normalize and pack, last stage of the multi-cycle unit
 * Finds the leading one of the product, builds exponent and fraction,
 * resolves overflow, underflow and specials, and selects the result
 */

`timescale 1ns/1ps
`default_nettype none

module mc_normalize_pack
	import mc_alu_pkg::*;
(
	mc_stage_if.receiver           slot_i,
	output logic                   valid_o,
	output logic [WORD_WIDTH-1:0]  result_o
);

	localparam int POS_WIDTH = $clog2(PRODUCT_WIDTH);

	logic [POS_WIDTH-1:0]           lead_pos;
	logic                           prod_zero;
	logic [PRODUCT_WIDTH-1:0]       norm_product;
	logic [FRAC_WIDTH-1:0]          fraction;
	logic signed [SCALE_WIDTH-1:0]  exp_sum;
	logic [WORD_WIDTH-1:0]          inf_word;
	logic [WORD_WIDTH-1:0]          zero_word;

	// Priority scan, the highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < PRODUCT_WIDTH; i++)
		begin
			if (slot_i.product[i])
				lead_pos = POS_WIDTH'(i);
		end
	end

	assign prod_zero = slot_i.product == '0;

	// Leading one moves to the top bit, fraction is what follows, truncated
	assign norm_product = slot_i.product << (PRODUCT_WIDTH - 1 - lead_pos);
	assign fraction = norm_product[PRODUCT_WIDTH-2 -: FRAC_WIDTH];

	// Biased exponent of the normalized result
	assign exp_sum = slot_i.scale + SCALE_WIDTH'(lead_pos);

	assign inf_word = {slot_i.sign, EXP_WIDTH'(EXP_MAX), FRAC_WIDTH'(0)};
	assign zero_word = {slot_i.sign, {(WORD_WIDTH-1){1'b0}}};

	always_comb
	begin
		case (slot_i.op)
			OP_IMUL:
			begin
				// Low word of the product, the same for signed and unsigned
				result_o = slot_i.product[WORD_WIDTH-1:0];
			end
			OP_FMUL, OP_ITOF:
			begin
				if (slot_i.is_nan)
					result_o = QNAN_WORD;
				else if (slot_i.is_inf || exp_sum >= EXP_MAX)
					result_o = inf_word;
				else if (prod_zero || exp_sum <= 0)
					result_o = zero_word;
				else
					result_o = {slot_i.sign, exp_sum[EXP_WIDTH-1:0], fraction};
			end
			default:
				result_o = '0;
		endcase
	end

	assign valid_o = slot_i.valid;

endmodule

`default_nettype wire

//--- src/mc_operand_unpack.sv
/*
 * Operand unpack, first stage of the multi-cycle unit
 * Classifies float operands, picks the multiplier inputs and the
 * scale exponent, then registers the slot
 */

`timescale 1ns/1ps
`default_nettype none

module mc_operand_unpack
	import mc_alu_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   valid_i,
	input  alu_op_e               op_i,
	input  wire [WORD_WIDTH-1:0]  operand1_i,
	input  wire [WORD_WIDTH-1:0]  operand2_i,
	mc_stage_if.sender            slot_o
);

	logic [EXP_WIDTH-1:0]          exp1, exp2;
	logic                          op1_zero, op2_zero;
	logic                          op1_inf, op2_inf;
	logic                          op1_nan, op2_nan;
	logic [SIG_WIDTH-1:0]          sig1, sig2;
	logic [WORD_WIDTH-1:0]         magnitude;

	logic [WORD_WIDTH-1:0]         next_multiplicand;
	logic [WORD_WIDTH-1:0]         next_multiplier;
	logic signed [SCALE_WIDTH-1:0] next_scale;
	logic                          next_sign;
	logic                          next_nan;
	logic                          next_inf;

	assign exp1 = operand1_i[WORD_WIDTH-2 -: EXP_WIDTH];
	assign exp2 = operand2_i[WORD_WIDTH-2 -: EXP_WIDTH];

	// Zero exponent field reads as zero, denormals included
	assign op1_zero = exp1 == '0;
	assign op2_zero = exp2 == '0;
	assign op1_inf = exp1 == EXP_WIDTH'(EXP_MAX) && operand1_i[FRAC_WIDTH-1:0] == '0;
	assign op2_inf = exp2 == EXP_WIDTH'(EXP_MAX) && operand2_i[FRAC_WIDTH-1:0] == '0;
	assign op1_nan = exp1 == EXP_WIDTH'(EXP_MAX) && operand1_i[FRAC_WIDTH-1:0] != '0;
	assign op2_nan = exp2 == EXP_WIDTH'(EXP_MAX) && operand2_i[FRAC_WIDTH-1:0] != '0;

	// Hidden one attached, zero operands contribute a zero significand
	assign sig1 = op1_zero ? '0 : {1'b1, operand1_i[FRAC_WIDTH-1:0]};
	assign sig2 = op2_zero ? '0 : {1'b1, operand2_i[FRAC_WIDTH-1:0]};

	// Two's complement magnitude, 80000000 stays as is
	assign magnitude = operand1_i[WORD_WIDTH-1] ? -operand1_i : operand1_i;

	always_comb
	begin
		next_multiplicand = '0;
		next_multiplier = '0;
		next_scale = '0;
		next_sign = 1'b0;
		next_nan = 1'b0;
		next_inf = 1'b0;
		case (op_i)
			OP_IMUL:
			begin
				next_multiplicand = operand1_i;
				next_multiplier = operand2_i;
			end
			OP_FMUL:
			begin
				next_multiplicand = WORD_WIDTH'(sig1);
				next_multiplier = WORD_WIDTH'(sig2);
				next_scale = SCALE_WIDTH'(exp1) + SCALE_WIDTH'(exp2)
					- SCALE_WIDTH'(FMUL_SCALE_ADJ);
				next_sign = operand1_i[WORD_WIDTH-1] ^ operand2_i[WORD_WIDTH-1];
				next_nan = op1_nan || op2_nan || (op1_inf && op2_zero)
					|| (op1_zero && op2_inf);
				next_inf = !next_nan && (op1_inf || op2_inf);
			end
			OP_ITOF:
			begin
				// Multiply by one so the back end only has to normalize
				next_multiplicand = magnitude;
				next_multiplier = WORD_WIDTH'(1);
				next_scale = SCALE_WIDTH'(EXP_BIAS);
				next_sign = operand1_i[WORD_WIDTH-1];
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			slot_o.valid <= 1'b0;
			slot_o.op <= OP_IMUL;
			slot_o.multiplicand <= '0;
			slot_o.multiplier <= '0;
			slot_o.scale <= '0;
			slot_o.sign <= 1'b0;
			slot_o.is_nan <= 1'b0;
			slot_o.is_inf <= 1'b0;
		end
		else
		begin
			slot_o.valid <= valid_i;
			slot_o.op <= op_i;
			slot_o.multiplicand <= next_multiplicand;
			slot_o.multiplier <= next_multiplier;
			slot_o.scale <= next_scale;
			slot_o.sign <= next_sign;
			slot_o.is_nan <= next_nan;
			slot_o.is_inf <= next_inf;
		end
	end

	// No product yet at this point
	assign slot_o.product = '0;

endmodule

`default_nettype wire

//--- src/mc_product_pipe.sv
/*
 * Product pipeline of the multi-cycle unit
 * One unsigned 32x32 multiply followed by MUL_STAGES register stages,
 * with the slot sideband delayed alongside
 */

`timescale 1ns/1ps
`default_nettype none

module mc_product_pipe
	import mc_alu_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input  wire           clk,
	input  wire           reset,
	mc_stage_if.receiver  slot_i,
	mc_stage_if.sender    slot_o
);

	logic [PRODUCT_WIDTH-1:0]       product_in;

	logic [PRODUCT_WIDTH-1:0]       product_q [MUL_STAGES];
	logic                           valid_q [MUL_STAGES];
	alu_op_e                        op_q [MUL_STAGES];
	logic signed [SCALE_WIDTH-1:0]  scale_q [MUL_STAGES];
	logic                           sign_q [MUL_STAGES];
	logic                           nan_q [MUL_STAGES];
	logic                           inf_q [MUL_STAGES];

	// Written once, the registers behind it are free to be retimed into it
	assign product_in = PRODUCT_WIDTH'(slot_i.multiplicand) * PRODUCT_WIDTH'(slot_i.multiplier);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < MUL_STAGES; i++)
			begin
				product_q[i] <= '0;
				valid_q[i] <= 1'b0;
				op_q[i] <= OP_IMUL;
				scale_q[i] <= '0;
				sign_q[i] <= 1'b0;
				nan_q[i] <= 1'b0;
				inf_q[i] <= 1'b0;
			end
		end
		else
		begin
			product_q[0] <= product_in;
			valid_q[0] <= slot_i.valid;
			op_q[0] <= slot_i.op;
			scale_q[0] <= slot_i.scale;
			sign_q[0] <= slot_i.sign;
			nan_q[0] <= slot_i.is_nan;
			inf_q[0] <= slot_i.is_inf;

			// Each stage may hold a different operation
			for (int i = 1; i < MUL_STAGES; i++)
			begin
				product_q[i] <= product_q[i-1];
				valid_q[i] <= valid_q[i-1];
				op_q[i] <= op_q[i-1];
				scale_q[i] <= scale_q[i-1];
				sign_q[i] <= sign_q[i-1];
				nan_q[i] <= nan_q[i-1];
				inf_q[i] <= inf_q[i-1];
			end
		end
	end

	assign slot_o.valid = valid_q[MUL_STAGES-1];
	assign slot_o.op = op_q[MUL_STAGES-1];
	assign slot_o.product = product_q[MUL_STAGES-1];
	assign slot_o.scale = scale_q[MUL_STAGES-1];
	assign slot_o.sign = sign_q[MUL_STAGES-1];
	assign slot_o.is_nan = nan_q[MUL_STAGES-1];
	assign slot_o.is_inf = inf_q[MUL_STAGES-1];

	// Operands are consumed here
	assign slot_o.multiplicand = '0;
	assign slot_o.multiplier = '0;

endmodule

`default_nettype wire

//--- src/mc_stage_if.sv
/*
 * Pipeline slot between the stages of the multi-cycle unit
 * Carries operands or product together with the float sideband
 */

`timescale 1ns/1ps
`default_nettype none

interface mc_stage_if
	import mc_alu_pkg::*;
();

	logic                           valid;
	alu_op_e                        op;
	logic [WORD_WIDTH-1:0]          multiplicand;
	logic [WORD_WIDTH-1:0]          multiplier;
	logic [PRODUCT_WIDTH-1:0]       product;
	logic signed [SCALE_WIDTH-1:0]  scale;
	logic                           sign;
	logic                           is_nan;
	logic                           is_inf;

	modport sender (
		output valid, op, multiplicand, multiplier, product,
		output scale, sign, is_nan, is_inf
	);

	modport receiver (
		input valid, op, multiplicand, multiplier, product,
		input scale, sign, is_nan, is_inf
	);

endinterface

`default_nettype wire

//--- src/multi_cycle_scalar_alu.sv
/*
 * Multi-cycle scalar unit for IMUL, FMUL and ITOF
 * Fully pipelined, result valid MUL_STAGES+1 cycles after issue
 */

`timescale 1ns/1ps
`default_nettype none

module multi_cycle_scalar_alu
	import mc_alu_pkg::*;
#(
	parameter int MUL_STAGES = 3
)
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   valid_i,
	input  alu_op_e               op_i,
	input  wire [WORD_WIDTH-1:0]  operand1_i,
	input  wire [WORD_WIDTH-1:0]  operand2_i,
	output logic                  valid_o,
	output logic [WORD_WIDTH-1:0] result_o
);

	// Unpack to product pipe
	mc_stage_if slot_a ();
	// Product pipe to normalize
	mc_stage_if slot_b ();

	mc_operand_unpack u_operand_unpack (
		.clk        (clk),
		.reset      (reset),
		.valid_i    (valid_i),
		.op_i       (op_i),
		.operand1_i (operand1_i),
		.operand2_i (operand2_i),
		.slot_o     (slot_a.sender)
	);

	mc_product_pipe #(
		.MUL_STAGES (MUL_STAGES)
	) u_product_pipe (
		.clk    (clk),
		.reset  (reset),
		.slot_i (slot_a.receiver),
		.slot_o (slot_b.sender)
	);

	mc_normalize_pack u_normalize_pack (
		.slot_i   (slot_b.receiver),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

endmodule

`default_nettype wire

//--- tb.f
src/mc_alu_pkg.sv
src/mc_stage_if.sv
src/mc_operand_unpack.sv
src/mc_product_pipe.sv
src/mc_normalize_pack.sv
src/multi_cycle_scalar_alu.sv
sim/mc_alu_sva.sv
sim/tb_multi_cycle_scalar_alu.sv
